// File: cpu_pkg.sv
package cpu_pkg;

    parameter int XLEN = 32;
    parameter int REG_ADDR_BITS = 5;

    // Instruction field positions
    parameter int RD_LSB = 7;
    parameter int FUNCT3_LSB = 12;
    parameter int RS1_LSB = 15;
    parameter int RS2_LSB = 20;
    parameter int FUNCT7_LSB = 25;

    typedef enum logic [6:0] {
        op_reg    = 7'b0110011,
        op_imm    = 7'b0010011,
        op_lui    = 7'b0110111,
        op_load   = 7'b0000011,
        op_store  = 7'b0100011,
        op_branch = 7'b1100011
    } opcode_e;

    typedef enum logic [2:0] {
        alu_add,
        alu_sub,
        alu_and,
        alu_or,
        alu_xor,
        alu_slt,
        alu_pass_b // LUI
    } alu_op_e;

    typedef enum logic [0:0] {
        wb_alu,
        wb_mem
    } wb_src_e;

endpackage

// File: register_bank.sv
`timescale 1ns/1ps

module register_bank (
    input  logic                             clock,
    input  logic                             rst,
    input  logic                             write_enable,
    input  logic [cpu_pkg::REG_ADDR_BITS-1:0] write_address,
    input  logic [cpu_pkg::XLEN-1:0]          write_value,
    input  logic [cpu_pkg::REG_ADDR_BITS-1:0] read_address1,
    input  logic [cpu_pkg::REG_ADDR_BITS-1:0] read_address2,
    output logic [cpu_pkg::XLEN-1:0]          value1,
    output logic [cpu_pkg::XLEN-1:0]          value2
);

    logic [cpu_pkg::XLEN-1:0] regs [2**cpu_pkg::REG_ADDR_BITS];

    // Same-cycle write passes straight through to the readers
    assign value1 = (read_address1 == '0) ? '0 :
                    (write_enable && write_address == read_address1) ? write_value :
                    regs[read_address1];
    assign value2 = (read_address2 == '0) ? '0 :
                    (write_enable && write_address == read_address2) ? write_value :
                    regs[read_address2];

    always_ff @(posedge clock) begin
        if (write_enable && write_address != '0) begin
            regs[write_address] <= write_value;
        end
    end

    // Writeback filters x0, so no write ever targets it
    a_no_x0_write: assert property (@(posedge clock) disable iff (rst)
        !(write_enable && write_address == '0));

endmodule

// File: ram.sv
`timescale 1ns/1ps

module ram #(
    parameter int RAM_ADDR_BITS = 6
) (
    input  logic                     clock,
    input  logic                     write_enable,
    input  logic [RAM_ADDR_BITS-1:0] address,
    input  logic [cpu_pkg::XLEN-1:0] data_in,
    output logic [cpu_pkg::XLEN-1:0] data_out
);

    logic [cpu_pkg::XLEN-1:0] mem [2**RAM_ADDR_BITS];

    assign data_out = mem[address]; // Asynchronous read

    always_ff @(posedge clock) begin
        if (write_enable) begin
            mem[address] <= data_in;
        end
    end

endmodule

// File: fetch.sv
`timescale 1ns/1ps

module fetch #(
    parameter int ROM_ADDR_BITS = 7
) (
    input  logic                     clock,
    input  logic                     rst,
    input  logic                     enable,
    input  logic                     redirect,
    input  logic [cpu_pkg::XLEN-1:0] target,
    input  logic [cpu_pkg::XLEN-1:0] rom_data,
    output logic [ROM_ADDR_BITS-1:0] rom_address,
    output logic [cpu_pkg::XLEN-1:0] pc,
    output logic [cpu_pkg::XLEN-1:0] instr,
    output logic                     valid
);

    logic [cpu_pkg::XLEN-1:0] fetch_pc;

    assign rom_address = fetch_pc[ROM_ADDR_BITS+1:2]; // Word index

    always_ff @(posedge clock) begin
        if (rst) begin
            fetch_pc <= '0;
            valid    <= 1'b0;
        end else if (enable) begin
            fetch_pc <= redirect ? target : fetch_pc + 32'd4;
            valid    <= !redirect; // Younger fetch is squashed
        end
    end

    // Fetch/decode payload
    always_ff @(posedge clock) begin
        if (enable) begin
            pc    <= fetch_pc;
            instr <= rom_data;
        end
    end

    // Branch targets come from execute, so alignment spans both stages
    a_pc_aligned: assert property (@(posedge clock) disable iff (rst) fetch_pc[1:0] == 2'b00);

endmodule

// File: decode.sv
`timescale 1ns/1ps

module decode (
    input  logic                             clock,
    input  logic                             rst,
    input  logic                             enable,
    input  logic                             flush,
    input  logic                             in_valid,
    input  logic [cpu_pkg::XLEN-1:0]          in_pc,
    input  logic [cpu_pkg::XLEN-1:0]          instr,
    input  logic [cpu_pkg::XLEN-1:0]          value1,
    input  logic [cpu_pkg::XLEN-1:0]          value2,
    output logic [cpu_pkg::REG_ADDR_BITS-1:0] rs1,
    output logic [cpu_pkg::REG_ADDR_BITS-1:0] rs2,
    output logic [cpu_pkg::XLEN-1:0]          imm,
    output cpu_pkg::alu_op_e                  alu_op,
    output logic                             alu_src,
    output logic                             branch,
    output logic                             branch_ne,
    output logic                             mem_read,
    output logic                             mem_write,
    output logic                             reg_write,
    output logic [cpu_pkg::REG_ADDR_BITS-1:0] rd,
    output cpu_pkg::wb_src_e                  wb_src,
    output logic [cpu_pkg::XLEN-1:0]          pc,
    output logic [cpu_pkg::XLEN-1:0]          rs1_value,
    output logic [cpu_pkg::XLEN-1:0]          rs2_value,
    output logic                             out_valid
);

    cpu_pkg::opcode_e         opcode;
    logic [2:0]               funct3;
    logic [cpu_pkg::XLEN-1:0] imm_i, imm_s, imm_b, imm_u;
    logic [cpu_pkg::XLEN-1:0] imm_next;
    cpu_pkg::alu_op_e         alu_next;
    cpu_pkg::wb_src_e         wb_next;
    logic                     known, src_next, br_next, ne_next;
    logic                     rd_mem_next, wr_mem_next, wr_reg_next;

    assign opcode = cpu_pkg::opcode_e'(instr[6:0]);
    assign funct3 = instr[cpu_pkg::FUNCT3_LSB +: 3];
    assign rs1    = instr[cpu_pkg::RS1_LSB +: cpu_pkg::REG_ADDR_BITS];
    assign rs2    = instr[cpu_pkg::RS2_LSB +: cpu_pkg::REG_ADDR_BITS];

    assign imm_i = {{20{instr[31]}}, instr[31:20]};
    assign imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};
    assign imm_b = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
    assign imm_u = {instr[31:12], 12'b0};

    always_comb begin
        known       = 1'b1;
        imm_next    = imm_i;
        alu_next    = cpu_pkg::alu_add;
        src_next    = 1'b0;
        br_next     = 1'b0;
        ne_next     = 1'b0;
        rd_mem_next = 1'b0;
        wr_mem_next = 1'b0;
        wr_reg_next = 1'b0;
        wb_next     = cpu_pkg::wb_alu;
        case (opcode)
            cpu_pkg::op_reg: begin
                wr_reg_next = 1'b1;
                case (funct3)
                    3'b000: alu_next = instr[cpu_pkg::FUNCT7_LSB + 5] ? cpu_pkg::alu_sub
                                                                       : cpu_pkg::alu_add;
                    3'b111: alu_next = cpu_pkg::alu_and;
                    3'b110: alu_next = cpu_pkg::alu_or;
                    3'b100: alu_next = cpu_pkg::alu_xor;
                    3'b010: alu_next = cpu_pkg::alu_slt;
                    default: known = 1'b0;
                endcase
            end
            cpu_pkg::op_imm: begin // ADDI only
                wr_reg_next = 1'b1;
                src_next    = 1'b1;
                known       = (funct3 == 3'b000);
            end
            cpu_pkg::op_lui: begin
                wr_reg_next = 1'b1;
                src_next    = 1'b1;
                alu_next    = cpu_pkg::alu_pass_b;
                imm_next    = imm_u;
            end
            cpu_pkg::op_load: begin
                wr_reg_next = 1'b1;
                src_next    = 1'b1;
                rd_mem_next = 1'b1;
                wb_next     = cpu_pkg::wb_mem;
            end
            cpu_pkg::op_store: begin
                src_next    = 1'b1;
                wr_mem_next = 1'b1;
                imm_next    = imm_s;
            end
            cpu_pkg::op_branch: begin
                br_next  = 1'b1;
                ne_next  = funct3[0];
                imm_next = imm_b;
                known    = (funct3[2:1] == 2'b00); // BEQ, BNE
            end
            default: known = 1'b0; // Bubble
        endcase
    end

    always_ff @(posedge clock) begin
        if (rst) begin
            out_valid <= 1'b0;
        end else if (enable) begin
            out_valid <= in_valid && known && !flush;
        end
    end

    // Decode/execute payload, qualified downstream by out_valid
    always_ff @(posedge clock) begin
        if (enable) begin
            imm       <= imm_next;
            alu_op    <= alu_next;
            alu_src   <= src_next;
            branch    <= br_next;
            branch_ne <= ne_next;
            mem_read  <= rd_mem_next;
            mem_write <= wr_mem_next;
            reg_write <= wr_reg_next;
            rd        <= instr[cpu_pkg::RD_LSB +: cpu_pkg::REG_ADDR_BITS];
            wb_src    <= wb_next;
            pc        <= in_pc;
            rs1_value <= value1;
            rs2_value <= value2;
        end
    end

endmodule

// File: execute.sv
`timescale 1ns/1ps

module execute (
    input  logic                             clock,
    input  logic                             rst,
    input  logic                             enable,
    input  logic                             de_valid,
    input  logic [cpu_pkg::XLEN-1:0]          de_pc,
    input  logic [cpu_pkg::XLEN-1:0]          rs1_value,
    input  logic [cpu_pkg::XLEN-1:0]          rs2_value,
    input  logic [cpu_pkg::XLEN-1:0]          imm,
    input  cpu_pkg::alu_op_e                  alu_op,
    input  logic                             alu_src,
    input  logic                             branch,
    input  logic                             branch_ne,
    input  logic                             de_mem_read,
    input  logic                             de_mem_write,
    input  logic                             de_reg_write,
    input  logic [cpu_pkg::REG_ADDR_BITS-1:0] de_rd,
    input  cpu_pkg::wb_src_e                  de_wb_src,
    output logic                             redirect,
    output logic [cpu_pkg::XLEN-1:0]          target,
    output logic [5:0]                       led_bits,
    output logic [cpu_pkg::XLEN-1:0]          result,
    output logic [cpu_pkg::XLEN-1:0]          store_data,
    output logic                             mem_read,
    output logic                             mem_write,
    output logic                             reg_write,
    output logic [cpu_pkg::REG_ADDR_BITS-1:0] rd,
    output cpu_pkg::wb_src_e                  wb_src
);

    logic [cpu_pkg::XLEN-1:0] operand_b;
    logic [cpu_pkg::XLEN-1:0] alu_out;

    assign operand_b = alu_src ? imm : rs2_value;

    always_comb begin
        case (alu_op)
            cpu_pkg::alu_add: alu_out = rs1_value + operand_b;
            cpu_pkg::alu_sub: alu_out = rs1_value - operand_b;
            cpu_pkg::alu_and: alu_out = rs1_value & operand_b;
            cpu_pkg::alu_or:  alu_out = rs1_value | operand_b;
            cpu_pkg::alu_xor: alu_out = rs1_value ^ operand_b;
            cpu_pkg::alu_slt: alu_out = {31'b0, $signed(rs1_value) < $signed(operand_b)};
            default:          alu_out = operand_b; // Pass B
        endcase
    end

    // BEQ taken on equal, BNE on not equal
    assign redirect = de_valid && branch && ((rs1_value == rs2_value) != branch_ne);
    assign target   = de_pc + imm;
    assign led_bits = result[5:0];

    always_ff @(posedge clock) begin
        if (rst) begin
            result    <= '0; // led reads 0 after reset
            mem_read  <= 1'b0;
            mem_write <= 1'b0;
            reg_write <= 1'b0;
        end else if (enable) begin
            result    <= alu_out;
            mem_read  <= de_valid && de_mem_read;
            mem_write <= de_valid && de_mem_write;
            reg_write <= de_valid && de_reg_write;
        end
    end

    always_ff @(posedge clock) begin
        if (enable) begin
            store_data <= rs2_value;
            rd         <= de_rd;
            wb_src     <= de_wb_src;
        end
    end

endmodule

// File: memory.sv
`timescale 1ns/1ps

module memory #(
    parameter int RAM_ADDR_BITS = 6
) (
    input  logic                             clock,
    input  logic                             rst,
    input  logic                             enable,
    input  logic [cpu_pkg::XLEN-1:0]          ex_result,
    input  logic [cpu_pkg::XLEN-1:0]          ex_store_data,
    input  logic                             ex_mem_read,
    input  logic                             ex_mem_write,
    input  logic                             ex_reg_write,
    input  logic [cpu_pkg::REG_ADDR_BITS-1:0] ex_rd,
    input  cpu_pkg::wb_src_e                  ex_wb_src,
    input  logic [cpu_pkg::XLEN-1:0]          ram_data_out,
    output logic [RAM_ADDR_BITS-1:0]         mem_addr,
    output logic [cpu_pkg::XLEN-1:0]          mem_write_data,
    output logic                             mem_write_enable,
    output logic [cpu_pkg::XLEN-1:0]          load_data,
    output logic [cpu_pkg::XLEN-1:0]          alu_result,
    output logic                             reg_write,
    output logic [cpu_pkg::REG_ADDR_BITS-1:0] rd,
    output cpu_pkg::wb_src_e                  wb_src
);

    assign mem_addr         = ex_result[RAM_ADDR_BITS+1:2]; // Byte address to word index
    assign mem_write_data   = ex_store_data;
    assign mem_write_enable = ex_mem_write && enable; // ex_mem_write already valid-qualified

    always_ff @(posedge clock) begin
        if (rst) begin
            reg_write <= 1'b0;
        end else if (enable) begin
            reg_write <= ex_reg_write;
        end
    end

    always_ff @(posedge clock) begin
        if (enable) begin
            if (ex_mem_read) begin
                load_data <= ram_data_out;
            end
            alu_result <= ex_result;
            rd         <= ex_rd;
            wb_src     <= ex_wb_src;
        end
    end

    // Decode never sets both for one instruction
    a_rw_exclusive: assert property (@(posedge clock) disable iff (rst)
        !(ex_mem_read && ex_mem_write));

endmodule

// File: writeback.sv
`timescale 1ns/1ps

module writeback (
    input  logic                             enable,
    input  logic                             reg_write,
    input  logic [cpu_pkg::REG_ADDR_BITS-1:0] rd,
    input  cpu_pkg::wb_src_e                  wb_src,
    input  logic [cpu_pkg::XLEN-1:0]          load_data,
    input  logic [cpu_pkg::XLEN-1:0]          alu_result,
    output logic                             write_enable,
    output logic [cpu_pkg::REG_ADDR_BITS-1:0] write_address,
    output logic [cpu_pkg::XLEN-1:0]          write_value
);

    // No commit to x0 and none while stalled
    assign write_enable  = enable && reg_write && (rd != '0);
    assign write_address = rd;
    assign write_value   = (wb_src == cpu_pkg::wb_mem) ? load_data : alu_result;

endmodule

// File: cpu.sv
`timescale 1ns/1ps

module cpu #(
    parameter int ROM_ADDR_BITS = 7,
    parameter int RAM_ADDR_BITS = 6
) (
    input  logic                             clock,
    input  logic                             rst,
    input  logic                             enable,
    input  logic [cpu_pkg::XLEN-1:0]          rom_data,
    output logic [ROM_ADDR_BITS-1:0]         rom_address,
    output logic [5:0]                       led,
    output logic                             commit,
    output logic [cpu_pkg::REG_ADDR_BITS-1:0] commit_rd,
    output logic [cpu_pkg::XLEN-1:0]          commit_data
);

    localparam int W = cpu_pkg::XLEN;
    localparam int R = cpu_pkg::REG_ADDR_BITS;

    // Register bank and RAM
    logic [R-1:0]             rb_rs1, rb_rs2;
    logic [W-1:0]             rb_value1, rb_value2;
    logic [RAM_ADDR_BITS-1:0] ram_address;
    logic [W-1:0]             ram_data_in, ram_data_out;
    logic                     ram_write_enable;

    // Fetch -> decode
    logic [W-1:0] if_de_pc, if_de_instr;
    logic         if_de_valid;

    // Decode -> execute
    logic [W-1:0]     de_ex_imm, de_ex_pc, de_ex_rs1_value, de_ex_rs2_value;
    cpu_pkg::alu_op_e de_ex_alu_op;
    cpu_pkg::wb_src_e de_ex_wb_src;
    logic             de_ex_alu_src, de_ex_branch, de_ex_branch_ne, de_ex_valid;
    logic             de_ex_mem_read, de_ex_mem_write, de_ex_reg_write;
    logic [R-1:0]     de_ex_rd;

    // Execute -> fetch/decode and memory
    logic             ex_redirect;
    logic [W-1:0]     ex_target, ex_mem_result, ex_mem_store_data;
    logic             ex_mem_mem_read, ex_mem_mem_write, ex_mem_reg_write;
    logic [R-1:0]     ex_mem_rd;
    cpu_pkg::wb_src_e ex_mem_wb_src;

    // Memory -> writeback
    logic [W-1:0]     mem_wb_load_data, mem_wb_alu_result;
    logic             mem_wb_reg_write;
    logic [R-1:0]     mem_wb_rd;
    cpu_pkg::wb_src_e mem_wb_wb_src;

    fetch #(.ROM_ADDR_BITS(ROM_ADDR_BITS)) u_fetch (
        .clock(clock), .rst(rst), .enable(enable),
        .redirect(ex_redirect), .target(ex_target),
        .rom_data(rom_data), .rom_address(rom_address),
        .pc(if_de_pc), .instr(if_de_instr), .valid(if_de_valid)
    );

    decode u_decode (
        .clock(clock), .rst(rst), .enable(enable), .flush(ex_redirect),
        .in_valid(if_de_valid), .in_pc(if_de_pc), .instr(if_de_instr),
        .value1(rb_value1), .value2(rb_value2), .rs1(rb_rs1), .rs2(rb_rs2),
        .imm(de_ex_imm), .alu_op(de_ex_alu_op), .alu_src(de_ex_alu_src),
        .branch(de_ex_branch), .branch_ne(de_ex_branch_ne),
        .mem_read(de_ex_mem_read), .mem_write(de_ex_mem_write),
        .reg_write(de_ex_reg_write), .rd(de_ex_rd), .wb_src(de_ex_wb_src),
        .pc(de_ex_pc), .rs1_value(de_ex_rs1_value), .rs2_value(de_ex_rs2_value),
        .out_valid(de_ex_valid)
    );

    execute u_execute (
        .clock(clock), .rst(rst), .enable(enable),
        .de_valid(de_ex_valid), .de_pc(de_ex_pc),
        .rs1_value(de_ex_rs1_value), .rs2_value(de_ex_rs2_value), .imm(de_ex_imm),
        .alu_op(de_ex_alu_op), .alu_src(de_ex_alu_src),
        .branch(de_ex_branch), .branch_ne(de_ex_branch_ne),
        .de_mem_read(de_ex_mem_read), .de_mem_write(de_ex_mem_write),
        .de_reg_write(de_ex_reg_write), .de_rd(de_ex_rd), .de_wb_src(de_ex_wb_src),
        .redirect(ex_redirect), .target(ex_target), .led_bits(led),
        .result(ex_mem_result), .store_data(ex_mem_store_data),
        .mem_read(ex_mem_mem_read), .mem_write(ex_mem_mem_write),
        .reg_write(ex_mem_reg_write), .rd(ex_mem_rd), .wb_src(ex_mem_wb_src)
    );

    memory #(.RAM_ADDR_BITS(RAM_ADDR_BITS)) u_memory (
        .clock(clock), .rst(rst), .enable(enable),
        .ex_result(ex_mem_result), .ex_store_data(ex_mem_store_data),
        .ex_mem_read(ex_mem_mem_read), .ex_mem_write(ex_mem_mem_write),
        .ex_reg_write(ex_mem_reg_write), .ex_rd(ex_mem_rd), .ex_wb_src(ex_mem_wb_src),
        .ram_data_out(ram_data_out), .mem_addr(ram_address),
        .mem_write_data(ram_data_in), .mem_write_enable(ram_write_enable),
        .load_data(mem_wb_load_data), .alu_result(mem_wb_alu_result),
        .reg_write(mem_wb_reg_write), .rd(mem_wb_rd), .wb_src(mem_wb_wb_src)
    );

    // Commit port mirrors the register bank write
    writeback u_writeback (
        .enable(enable), .reg_write(mem_wb_reg_write), .rd(mem_wb_rd),
        .wb_src(mem_wb_wb_src), .load_data(mem_wb_load_data),
        .alu_result(mem_wb_alu_result), .write_enable(commit),
        .write_address(commit_rd), .write_value(commit_data)
    );

    register_bank u_register_bank (
        .clock(clock), .rst(rst),
        .write_enable(commit), .write_address(commit_rd), .write_value(commit_data),
        .read_address1(rb_rs1), .read_address2(rb_rs2),
        .value1(rb_value1), .value2(rb_value2)
    );

    ram #(.RAM_ADDR_BITS(RAM_ADDR_BITS)) u_ram (
        .clock(clock), .write_enable(ram_write_enable), .address(ram_address),
        .data_in(ram_data_in), .data_out(ram_data_out)
    );

endmodule

// File: tb_cpu.sv
`timescale 1ns/1ps

module tb_cpu;

    logic        clock;
    logic        rst;
    logic        enable;
    logic [31:0] rom_data;
    logic [6:0]  rom_address;
    logic [5:0]  led;
    logic        commit;
    logic [4:0]  commit_rd;
    logic [31:0] commit_data;

    logic [31:0] rom [128];
    logic [31:0] regs_m [32];  // Register model
    logic [31:0] mem_m [64];   // RAM model, word indexed
    logic [4:0]  exp_rd [$];
    logic [31:0] exp_data [$];
    bit          exp_alu [$];
    logic [4:0]  saved_rd [$];
    logic [31:0] saved_data [$];
    bit          saved_alu [$];
    integer      seed = 32'h1f8aea8d;
    integer      slot;
    bit          live;

    cpu #(.ROM_ADDR_BITS(7), .RAM_ADDR_BITS(6)) uut (
        .clock(clock), .rst(rst), .enable(enable), .rom_data(rom_data),
        .rom_address(rom_address), .led(led), .commit(commit),
        .commit_rd(commit_rd), .commit_data(commit_data)
    );

    assign rom_data = rom[rom_address]; // Combinational ROM

    initial begin
        clock = 1'b0;
        forever #10 clock = ~clock;
    end

    task check(input string name, input logic [31:0] expected, input logic [31:0] actual);
        if (expected !== actual) begin
            $display("MISMATCH %s expected %h actual %h", name, expected, actual);
            $display("SIMULATION FAILED");
            $fatal(1);
        end
    endtask

    task fail_now(input string what);
        $display("%s", what);
        $display("SIMULATION FAILED");
        $fatal(1);
    endtask

    function logic [31:0] enc_r(input logic [6:0] f7, input logic [2:0] f3,
                                input logic [4:0] rd, input logic [4:0] rs1,
                                input logic [4:0] rs2);
        return {f7, rs2, rs1, f3, rd, cpu_pkg::op_reg};
    endfunction

    function logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
                                input logic [2:0] f3, input logic [4:0] rd,
                                input cpu_pkg::opcode_e op);
        return {imm, rs1, f3, rd, op};
    endfunction

    function logic [31:0] enc_s(input logic [11:0] imm, input logic [4:0] rs2,
                                input logic [4:0] rs1);
        return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], cpu_pkg::op_store};
    endfunction

    function logic [31:0] enc_b(input logic [12:0] imm, input logic [4:0] rs2,
                                input logic [4:0] rs1, input logic [2:0] f3);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], cpu_pkg::op_branch};
    endfunction

    task clear_program;
        for (int i = 0; i < 128; i++) rom[i] = 32'h0; // Opcode 0 is a bubble
        slot = 0;
        live = 1'b1;
        exp_rd.delete();
        exp_data.delete();
        exp_alu.delete();
    endtask

    task place(input logic [31:0] word, input bit gap);
        rom[slot] = word;
        slot = gap ? slot + 3 : slot + 1; // Two no-ops after producers
    endtask

    task expect_write(input logic [4:0] rd, input logic [31:0] data, input bit is_alu);
        if (live && rd != 5'd0) begin
            regs_m[rd] = data;
            exp_rd.push_back(rd);
            exp_data.push_back(data);
            exp_alu.push_back(is_alu);
        end
    endtask

    task do_lui(input logic [4:0] rd, input logic [19:0] imm);
        place({imm, rd, cpu_pkg::op_lui}, 1'b1);
        expect_write(rd, {imm, 12'b0}, 1'b1);
    endtask

    task do_addi(input logic [4:0] rd, input logic [4:0] rs1, input logic [11:0] imm);
        place(enc_i(imm, rs1, 3'b000, rd, cpu_pkg::op_imm), 1'b1);
        expect_write(rd, regs_m[rs1] + {{20{imm[11]}}, imm}, 1'b1);
    endtask

    task load_const(input logic [4:0] rd, input logic [31:0] value);
        logic [31:0] hi;
        hi = value + 32'h800; // ADDI sign-extends its low part
        do_lui(rd, hi[31:12]);
        do_addi(rd, rd, value[11:0]);
    endtask

    task do_rr(input cpu_pkg::alu_op_e op, input logic [4:0] rd,
               input logic [4:0] rs1, input logic [4:0] rs2);
        logic [31:0] a, b, r;
        logic [2:0]  f3;
        logic [6:0]  f7;
        a  = regs_m[rs1];
        b  = regs_m[rs2];
        f7 = 7'b0;
        case (op)
            cpu_pkg::alu_sub: begin
                f3 = 3'b000;
                f7 = 7'b0100000;
                r  = a - b;
            end
            cpu_pkg::alu_and: begin
                f3 = 3'b111;
                r  = a & b;
            end
            cpu_pkg::alu_or: begin
                f3 = 3'b110;
                r  = a | b;
            end
            cpu_pkg::alu_xor: begin
                f3 = 3'b100;
                r  = a ^ b;
            end
            cpu_pkg::alu_slt: begin
                f3 = 3'b010;
                r  = ($signed(a) < $signed(b)) ? 1 : 0;
            end
            default: begin
                f3 = 3'b000;
                r  = a + b;
            end
        endcase
        place(enc_r(f7, f3, rd, rs1, rs2), 1'b1);
        expect_write(rd, r, 1'b1);
    endtask

    task do_sw(input logic [4:0] rs2, input logic [4:0] rs1, input logic [11:0] imm);
        logic [31:0] addr;
        addr = regs_m[rs1] + {{20{imm[11]}}, imm};
        place(enc_s(imm, rs2, rs1), 1'b1);
        if (live) mem_m[addr[7:2]] = regs_m[rs2];
    endtask

    task do_lw(input logic [4:0] rd, input logic [4:0] rs1, input logic [11:0] imm);
        logic [31:0] addr;
        addr = regs_m[rs1] + {{20{imm[11]}}, imm};
        place(enc_i(imm, rs1, 3'b010, rd, cpu_pkg::op_load), 1'b1);
        expect_write(rd, mem_m[addr[7:2]], 1'b0);
    endtask

    task reset_dut;
        rst    = 1'b1;
        enable = 1'b1;
        repeat (10) @(negedge clock);
        #1;
        check("reset commit", 32'd0, {31'd0, commit});
        check("reset led", 32'd0, {26'd0, led});
        rst = 1'b0;
    endtask

    // Runs the ROM until the expected commits are drained
    task run_program(input string name, input bit stall, input int br_slot,
                     input int br_target);
        int         cycles, br_cycle, stall_left;
        bit         br_seen, prev_en;
        logic [5:0] last_led;
        logic [6:0] last_addr;
        cycles     = 0;
        br_cycle   = 0;
        br_seen    = 1'b0;
        stall_left = 0;
        prev_en    = 1'b1;
        last_led   = 6'd0;
        last_addr  = 7'd0;
        reset_dut();
        while (exp_rd.size() != 0 || stall_left > 0) begin
            if (cycles > 3000) fail_now({"Timeout waiting for commits in ", name});
            if (cycles > 0) @(negedge clock);
            if (stall && stall_left == 0 && ($unsigned($random(seed)) % 4) == 0) begin
                stall_left = 1 + ($unsigned($random(seed)) % 5);
            end
            enable = (stall_left == 0);
            if (stall_left > 0) stall_left--;
            #1;
            if (!prev_en) check({name, " stalled rom_address"}, last_addr, rom_address);
            if (!enable && commit) fail_now({"Commit seen while stalled in ", name});
            if (br_slot >= 0 && !br_seen && enable && rom_address == br_slot) begin
                br_seen  = 1'b1;
                br_cycle = cycles;
            end
            if (br_seen && cycles == br_cycle + 3) begin
                check({name, " branch target"}, br_target, {25'd0, rom_address});
            end
            if (commit) begin
                if (exp_rd.size() == 0) fail_now({"Unexpected extra commit in ", name});
                check({name, " rd"}, {27'd0, exp_rd[0]}, {27'd0, commit_rd});
                check({name, " data"}, exp_data[0], commit_data);
                if (exp_alu[0]) begin
                    check({name, " led"}, {26'd0, exp_data[0][5:0]}, {26'd0, last_led});
                end
                void'(exp_rd.pop_front());
                void'(exp_data.pop_front());
                void'(exp_alu.pop_front());
            end
            if (enable) last_led = led; // Result leaving execute at the next edge
            last_addr = rom_address;
            prev_en   = enable;
            cycles++;
        end
        enable = 1'b1;
        repeat (8) begin // Tail of no-ops commits nothing
            @(negedge clock);
            #1;
            if (commit) fail_now({"Unexpected commit after program end in ", name});
        end
    endtask

    task test_reset;
        clear_program();
        reset_dut();
        for (int i = 0; i < 6; i++) begin
            if (i > 0) @(negedge clock);
            #1;
            check("reset rom_address", i, {25'd0, rom_address});
            check("reset idle commit", 32'd0, {31'd0, commit});
        end
    endtask

    task build_arith;
        clear_program();
        for (int r = 0; r < 2; r++) begin
            load_const(5'd1, $random(seed));
            load_const(5'd2, $random(seed));
            do_rr(cpu_pkg::alu_add, 5'd3, 5'd1, 5'd2);
            do_rr(cpu_pkg::alu_sub, 5'd4, 5'd1, 5'd2);
            do_rr(cpu_pkg::alu_and, 5'd5, 5'd1, 5'd2);
            do_rr(cpu_pkg::alu_or,  5'd6, 5'd1, 5'd2);
            do_rr(cpu_pkg::alu_xor, 5'd7, 5'd1, 5'd2);
            do_rr(cpu_pkg::alu_slt, 5'd8, 5'd1, 5'd2);
            do_rr(cpu_pkg::alu_slt, 5'd9, 5'd2, 5'd1);
        end
    endtask

    task test_arith_and_stall;
        build_arith();
        saved_rd   = exp_rd;
        saved_data = exp_data;
        saved_alu  = exp_alu;
        run_program("arith", 1'b0, -1, 0);
        exp_rd   = saved_rd;
        exp_data = saved_data;
        exp_alu  = saved_alu;
        run_program("stall", 1'b1, -1, 0);
    endtask

    task test_memory;
        clear_program();
        for (int i = 1; i <= 4; i++) load_const(i[4:0], $random(seed));
        do_sw(5'd1, 5'd0, 12'd0);
        do_sw(5'd2, 5'd0, 12'd8);
        do_sw(5'd3, 5'd0, 12'd20);
        do_sw(5'd4, 5'd0, 12'd44);
        do_lw(5'd10, 5'd0, 12'd20);
        do_lw(5'd11, 5'd0, 12'd0);
        do_lw(5'd12, 5'd0, 12'd44);
        do_lw(5'd13, 5'd0, 12'd8);
        run_program("memory", 1'b0, -1, 0);
    endtask

    task test_branch;
        clear_program();
        do_addi(5'd1, 5'd0, 12'd5);
        do_addi(5'd2, 5'd0, 12'd5);
        place(enc_b(13'd24, 5'd2, 5'd1, 3'b000), 1'b0); // BEQ at 6 to 12
        live = 1'b0;
        for (int i = 0; i < 5; i++) begin // Squashed successors and skipped slots
            place(enc_i(12'd1, 5'd0, 3'b000, 5'd20 + i[4:0], cpu_pkg::op_imm), 1'b0);
        end
        live = 1'b1;
        do_addi(5'd6, 5'd0, 12'd7);
        place(enc_b(13'd8, 5'd2, 5'd1, 3'b001), 1'b0); // BNE, not taken
        do_addi(5'd7, 5'd0, 12'd9);
        do_addi(5'd8, 5'd0, 12'd10);
        run_program("branch", 1'b0, 6, 12);
    endtask

    initial begin
        rst    = 1'b1;
        enable = 1'b1;
        for (int i = 0; i < 32; i++) regs_m[i] = 32'h0;
        for (int i = 0; i < 64; i++) mem_m[i] = 32'h0;
        test_reset();
        test_arith_and_stall();
        test_memory();
        test_branch();
        $display("SIMULATION PASSED");
        $finish;
    end

endmodule

// File: cpu.f
cpu_pkg.sv
register_bank.sv
ram.sv
fetch.sv
decode.sv
execute.sv
memory.sv
writeback.sv
cpu.sv
tb_cpu.sv

// File: run.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"
rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal --top-module tb_cpu -f cpu.f -o tb_cpu
./obj_dir/tb_cpu
